//--- bench/branch_unit_tb.sv
`timescale 1ns/1ps
`include "branch_params.svh"

module branch_unit_tb;
	import branch_types_pkg::*;
	import branch_ctrl_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_CYCLES = 400 * NUM_TESTS;

	logic clk, reset, issue_valid, issue_ready, opd0_valid, opd1_valid, use_imm;
	logic cdb_valid, push, pop, commit, failure, flush, speculating;
	cmp_kind_t issue_kind;
	data_t opd0, opd1, cdb_data;
	tag_t opd0_tag, opd1_tag, rob_tag, cdb_tag, commit_tag;
	logic [`IMM_W-1:0] imm;
	pred_t pred;
	addr_t fail_addr, pc, redirect_addr, return_addr;

	logic [31:0] seed = 32'h5743f6b0;
	tag_t tag_ctr = '0;
	int errors = 0;
	int tests_ok = 0;
	logic flush_due = 1'b0;
	logic exp_fail [$];  // expected failure bit per branch, issue order
	addr_t exp_addr [$];
	cmp_kind_t kinds [3] = '{CMP_E, CMP_LE, CMP_FZ};

	branch_unit dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;  // lcg
		return seed;
	endfunction

	function automatic tag_t next_tag();
		tag_ctr = tag_ctr + 1'b1;
		if (tag_ctr == '0)
			tag_ctr = 4'd1;  // 0 means no commit
		return tag_ctr;
	endfunction

	function automatic data_t sign_extend(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic logic expected_outcome(input cmp_kind_t kind, input data_t a,
			input data_t b);
		case (kind)
			CMP_E: return a == b;
			CMP_LE: return $signed(a) <= $signed(b);
			default: return a[30:23] == 8'd0;  // exponent field
		endcase
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
			errors++;
		end
	endtask

	// commit side, sampled mid-cycle
	always @(negedge clk) begin
		if (!reset) begin
			check("flush", 32'(flush), 32'(flush_due));
			flush_due = 1'b0;
			if (commit && exp_fail.size() == 0) begin
				$display("at %0t ns: commit with no branch in flight", $time);
				errors++;
			end else if (commit) begin
				check("failure", 32'(failure), 32'(exp_fail[0]));
				check("redirect_addr", 32'(redirect_addr), 32'(exp_addr[0]));
				flush_due = exp_fail.pop_front();
				void'(exp_addr.pop_front());
			end
		end
	end

	task automatic issue_branch(input cmp_kind_t kind, input data_t a, input data_t b,
			input logic a_ok, input logic imm_sel, input pred_t p, input tag_t rt);
		data_t b_eff;
		int n;
		b_eff = imm_sel ? sign_extend(b[15:0]) : b;
		n = 0;
		issue_kind = kind;
		opd0 = a_ok ? a : ~a;  // stale value until the CDB delivers a
		opd1 = imm_sel ? next_rand() : b;
		opd0_valid = a_ok;
		opd1_valid = !imm_sel;
		use_imm = imm_sel;
		imm = b[15:0];
		pred = p;
		fail_addr = addr_t'(next_rand());
		rob_tag = rt;
		issue_valid = 1'b1;
		do begin
			@(negedge clk);
			n++;
		end while (!issue_ready && n < 50);
		if (issue_ready) begin
			exp_fail.push_back(expected_outcome(kind, a, b_eff) != p[1]);
			exp_addr.push_back(fail_addr);
		end else begin
			$display("at %0t ns: branch with tag %0d was never accepted", $time, rt);
			errors++;
		end
		@(posedge clk);
		#1;
		issue_valid = 1'b0;
	endtask

	task automatic wait_commit(input tag_t rt);
		int n;
		n = 0;
		commit_tag = rt;
		do begin
			@(negedge clk);
			n++;
		end while (!commit && n < 50);
		if (!commit) begin
			$display("at %0t ns: branch with tag %0d never committed", $time, rt);
			errors++;
		end
		@(posedge clk);
		#1;
		commit_tag = '0;
	endtask

	task automatic stack_op(input logic do_push, input addr_t addr, input addr_t want);
		push = do_push;
		pop = !do_push;
		pc = addr;
		@(posedge clk);
		#1;
		push = 1'b0;
		pop = 1'b0;
		check("return_addr", 32'(return_addr), 32'(want));  // registered, settled by now
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		if (errors == errs_before) begin
			tests_ok++;
			$display("test %0d %s: pass", num, name);
		end else
			$display("test %0d %s: fail, %0d errors", num, name, errors - errs_before);
	endtask

	initial begin
		data_t a, b, v;
		addr_t p1, p2;
		tag_t t [5];
		pred_t p;
		int mark;
		reset = 1'b1;
		{issue_valid, opd0_valid, opd1_valid, use_imm, cdb_valid, push, pop} = '0;
		issue_kind = CMP_E;
		{opd0, opd1, cdb_data, imm, pred, fail_addr, pc} = '0;
		{rob_tag, cdb_tag, commit_tag} = '0;
		opd0_tag = 4'hA;
		opd1_tag = 4'hB;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check("commit after reset", 32'(commit), 32'd0);
		check("speculating after reset", 32'(speculating), 32'd0);
		check("return_addr after reset", 32'(return_addr), 32'd0);
		@(posedge clk);
		#1;

		mark = errors;
		for (int i = 0; i < 12; i++) begin
			a = next_rand();
			b = next_rand();
			if ((i / 3) % 2 == 1) begin
				a = i >= 6 ? sign_extend(b[15:0]) : b;
				if (kinds[i % 3] == CMP_FZ)
					a = a & 32'h807f_ffff;
			end
			p = {expected_outcome(kinds[i % 3], a, i >= 6 ? sign_extend(b[15:0]) : b), 1'b1};
			t[0] = next_tag();
			issue_branch(kinds[i % 3], a, b, 1'b1, i >= 6, p, t[0]);
			wait_commit(t[0]);
		end
		report_test(1, "correct predictions", mark);

		mark = errors;
		a = next_rand();
		t[0] = next_tag();
		issue_branch(CMP_E, a, a + 1, 1'b1, 1'b0, 2'b11, t[0]);
		repeat (2) @(negedge clk);
		check("speculating", 32'(speculating), 32'd1);
		@(posedge clk);
		#1;
		wait_commit(t[0]);
		repeat (2) @(negedge clk);
		check("speculating after flush", 32'(speculating), 32'd0);
		@(posedge clk);
		#1;
		report_test(2, "misprediction", mark);

		mark = errors;
		v = next_rand();
		t[0] = next_tag();
		issue_branch(CMP_E, v, v, 1'b0, 1'b0, 2'b11, t[0]);
		commit_tag = t[0];
		repeat (4) begin
			@(negedge clk);
			check("commit before the CDB", 32'(commit), 32'd0);
		end
		@(posedge clk);
		#1;
		cdb_valid = 1'b1;
		cdb_tag = 4'hA;
		cdb_data = v;
		@(posedge clk);
		#1;
		cdb_valid = 1'b0;
		wait_commit(t[0]);
		report_test(3, "operand from CDB", mark);

		mark = errors;
		for (int i = 0; i < 5; i++)
			t[i] = next_tag();
		for (int i = 0; i < 4; i++)
			issue_branch(CMP_FZ, 32'd0, 32'd0, 1'b1, 1'b0, 2'b11, t[i]);
		fork
			issue_branch(CMP_FZ, 32'd0, 32'd0, 1'b1, 1'b0, 2'b11, t[4]);
			begin
				repeat (3) begin
					@(negedge clk);
					check("issue_ready while full", 32'(issue_ready), 32'd0);
				end
				@(posedge clk);
				#1;
				commit_tag = t[0];  // frees the oldest slot
			end
		join
		for (int i = 1; i < 5; i++)
			wait_commit(t[i]);
		report_test(4, "back-pressure", mark);

		mark = errors;
		p1 = addr_t'(next_rand());
		p2 = addr_t'(next_rand());
		stack_op(1'b1, p1, p1);
		stack_op(1'b1, p2, p2);
		stack_op(1'b0, '0, p1);
		report_test(5, "push and pop", mark);

		mark = errors;
		stack_op(1'b1, p2, p2);
		t[0] = next_tag();
		issue_branch(CMP_E, 32'd1, 32'd2, 1'b1, 1'b0, 2'b11, t[0]);
		stack_op(1'b1, ~p2, ~p2);  // speculative push
		wait_commit(t[0]);
		@(posedge clk);
		#1;
		check("return_addr after flush", 32'(return_addr), 32'(p2));
		stack_op(1'b0, '0, p1);
		report_test(6, "stack restore on flush", mark);

		repeat (2) @(negedge clk);
		if (exp_fail.size() != 0) begin
			$display("%0d branches were never committed", exp_fail.size());
			errors++;
		end
		$display("%0d of %0d tests ok, %0d errors", tests_ok, NUM_TESTS, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- branch_unit.f
+incdir+src
src/branch_types_pkg.sv
src/branch_ctrl_pkg.sv
src/compare_queue.sv
src/branch_queue.sv
src/return_stack.sv
src/spec_ctrl.sv
src/branch_unit.sv
bench/branch_unit_tb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator and run the branch_unit testbench
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module branch_unit_tb -f branch_unit.f -o branch_unit_sim &&
./obj_dir/branch_unit_sim | tee /dev/stderr | grep -x "all tests passed" > /dev/null &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- src/branch_ctrl_pkg.sv
package branch_ctrl_pkg;

	// two-bit saturating counter, bit 1 is the taken guess
	typedef logic [1:0] pred_t;

	typedef enum logic [1:0] {
		SPEC_IDLE,
		SPEC_ACTIVE,
		SPEC_RECOVER
	} spec_state_t;

endpackage

//--- src/branch_params.svh
`ifndef BRANCH_PARAMS_SVH
`define BRANCH_PARAMS_SVH

// queue sizing
`define BR_DEPTH 4
`define BR_CNT_W 3  // occupancy, 0 to BR_DEPTH
`define BR_AGE_W 2  // position inside a queue

// datapath widths
`define DATA_W 32
`define TAG_W 4     // rename and reorder tags
`define ADDR_W 16
`define IMM_W 16

// return stack, 8 entries
`define RAS_W 3

`endif

//--- src/branch_queue.sv
`timescale 1ns/1ps
`include "branch_params.svh"

module branch_queue (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic issue_valid,
	output logic issue_ready,
	input branch_ctrl_pkg::pred_t pred,
	input branch_types_pkg::addr_t fail_addr,
	input branch_types_pkg::tag_t rob_tag,
	input branch_types_pkg::sp_t stack_ptr,
	input logic resolve,
	input logic outcome,
	input logic [`BR_AGE_W-1:0] resolve_age,
	input branch_types_pkg::tag_t commit_tag,
	output logic commit,
	output logic failure,
	output branch_types_pkg::addr_t redirect_addr,
	output branch_types_pkg::sp_t restore_ptr,
	output logic count_nonzero
);
	import branch_types_pkg::*;
	import branch_ctrl_pkg::*;

	localparam int DEPTH = `BR_DEPTH;

	logic [`BR_CNT_W-1:0] cnt_q;
	logic accept;
	logic [`BR_AGE_W-1:0] mark_idx;
	logic [DEPTH-1:0] mark;

	pred_t pred_q [DEPTH];
	addr_t addr_q [DEPTH];
	tag_t rtag_q [DEPTH];
	sp_t sp_q [DEPTH];
	logic [DEPTH-1:0] res_q;
	logic [DEPTH-1:0] fail_q;
	sp_t restore_q;  // pointer saved by the last committed branch

	pred_t pred_v [DEPTH+1];
	addr_t addr_v [DEPTH+1];
	tag_t rtag_v [DEPTH+1];
	sp_t sp_v [DEPTH+1];
	logic [DEPTH:0] res_v;
	logic [DEPTH:0] fail_v;

	assign commit = !flush && cnt_q != 0 && res_q[0] && rtag_q[0] == commit_tag;
	assign issue_ready = !flush && (cnt_q < DEPTH || commit);
	assign accept = issue_valid && issue_ready;

	assign failure = fail_q[0];
	assign redirect_addr = addr_q[0];
	assign restore_ptr = restore_q;
	assign count_nonzero = cnt_q != 0;

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			if (i < int'(cnt_q)) begin
				pred_v[i] = pred_q[i];
				addr_v[i] = addr_q[i];
				rtag_v[i] = rtag_q[i];
				sp_v[i] = sp_q[i];
				res_v[i] = res_q[i];
				fail_v[i] = fail_q[i];
			end else begin
				pred_v[i] = pred;
				addr_v[i] = fail_addr;
				rtag_v[i] = rob_tag;
				sp_v[i] = stack_ptr;
				res_v[i] = 1'b0;
				fail_v[i] = 1'b0;
			end
		end
		pred_v[DEPTH] = pred;
		addr_v[DEPTH] = fail_addr;
		rtag_v[DEPTH] = rob_tag;
		sp_v[DEPTH] = stack_ptr;
		res_v[DEPTH] = 1'b0;
		fail_v[DEPTH] = 1'b0;
	end

	// resolved record moves down one slot if the head commits
	assign mark_idx = resolve_age - commit;

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			mark[i] = resolve && int'(mark_idx) == i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_q - commit + accept;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			pred_q[i] <= pred_v[i + commit];
			addr_q[i] <= addr_v[i + commit];
			rtag_q[i] <= rtag_v[i + commit];
			sp_q[i] <= sp_v[i + commit];
			res_q[i] <= res_v[i + commit] | mark[i];
			fail_q[i] <= fail_v[i + commit] | (mark[i] && outcome != pred_v[i + commit][1]);
		end
		if (commit)
			restore_q <= sp_q[0];
	end

	// a record needs an edge to resolve before it can leave
	assert property (@(posedge clk) disable iff (reset) commit |-> $past(cnt_q) != 0);

endmodule

//--- src/branch_types_pkg.sv
`include "branch_params.svh"

package branch_types_pkg;

	typedef logic [`DATA_W-1:0] data_t;
	typedef logic [`TAG_W-1:0] tag_t;
	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`RAS_W-1:0] sp_t;

	// compare kinds, code 2'd1 is unused
	typedef enum logic [1:0] {
		CMP_FZ = 2'd0,  // float exponent zero test
		CMP_E  = 2'd2,
		CMP_LE = 2'd3   // signed
	} cmp_kind_t;

endpackage

//--- src/branch_unit.sv
`timescale 1ns/1ps
`include "branch_params.svh"

module branch_unit (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	output logic issue_ready,
	input branch_types_pkg::cmp_kind_t issue_kind,
	input branch_types_pkg::data_t opd0,
	input branch_types_pkg::data_t opd1,
	input logic opd0_valid,
	input logic opd1_valid,
	input branch_types_pkg::tag_t opd0_tag,
	input branch_types_pkg::tag_t opd1_tag,
	input logic use_imm,
	input logic [`IMM_W-1:0] imm,
	input branch_ctrl_pkg::pred_t pred,
	input branch_types_pkg::addr_t fail_addr,
	input branch_types_pkg::tag_t rob_tag,
	input logic cdb_valid,
	input branch_types_pkg::tag_t cdb_tag,
	input branch_types_pkg::data_t cdb_data,
	input branch_types_pkg::tag_t commit_tag,
	input logic push,
	input logic pop,
	input branch_types_pkg::addr_t pc,
	output logic commit,
	output logic failure,
	output branch_types_pkg::addr_t redirect_addr,
	output logic flush,
	output logic speculating,
	output branch_types_pkg::addr_t return_addr
);
	import branch_types_pkg::*;

	logic resolve;
	logic outcome;
	logic [`BR_AGE_W-1:0] resolve_age;
	logic count_nonzero;
	sp_t stack_ptr;
	sp_t restore_ptr;

	compare_queue cmp_q_i (
		.clk(clk), .reset(reset), .flush(flush),
		.enq(issue_valid && issue_ready), .kind(issue_kind),
		.opd0(opd0), .opd1(opd1), .opd0_valid(opd0_valid), .opd1_valid(opd1_valid),
		.opd0_tag(opd0_tag), .opd1_tag(opd1_tag), .use_imm(use_imm), .imm(imm),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
		.deq_commit(commit), .resolve(resolve), .outcome(outcome),
		.resolve_age(resolve_age)
	);

	branch_queue br_q_i (
		.clk(clk), .reset(reset), .flush(flush),
		.issue_valid(issue_valid), .issue_ready(issue_ready),
		.pred(pred), .fail_addr(fail_addr), .rob_tag(rob_tag), .stack_ptr(stack_ptr),
		.resolve(resolve), .outcome(outcome), .resolve_age(resolve_age),
		.commit_tag(commit_tag), .commit(commit), .failure(failure),
		.redirect_addr(redirect_addr), .restore_ptr(restore_ptr),
		.count_nonzero(count_nonzero)
	);

	return_stack ras_i (
		.clk(clk), .reset(reset), .flush(flush), .push(push), .pop(pop), .pc(pc),
		.restore_ptr(restore_ptr), .stack_ptr(stack_ptr), .return_addr(return_addr)
	);

	spec_ctrl spec_i (
		.clk(clk), .reset(reset), .count_nonzero(count_nonzero), .commit(commit),
		.failure(failure), .flush(flush), .speculating(speculating)
	);

endmodule

//--- src/compare_queue.sv
`timescale 1ns/1ps
`include "branch_params.svh"

module compare_queue (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic enq,
	input branch_types_pkg::cmp_kind_t kind,
	input branch_types_pkg::data_t opd0,
	input branch_types_pkg::data_t opd1,
	input logic opd0_valid,
	input logic opd1_valid,
	input branch_types_pkg::tag_t opd0_tag,
	input branch_types_pkg::tag_t opd1_tag,
	input logic use_imm,
	input logic [`IMM_W-1:0] imm,
	input logic cdb_valid,
	input branch_types_pkg::tag_t cdb_tag,
	input branch_types_pkg::data_t cdb_data,
	input logic deq_commit,
	output logic resolve,
	output logic outcome,
	output logic [`BR_AGE_W-1:0] resolve_age
);
	import branch_types_pkg::*;

	localparam int DEPTH = `BR_DEPTH;

	logic [`BR_CNT_W-1:0] cnt_q;   // compares still pending
	logic [`BR_CNT_W-1:0] done_q;  // resolved, branch not yet committed

	cmp_kind_t kind_q [DEPTH];
	data_t [1:0] opd_q [DEPTH];
	tag_t [1:0] tag_q [DEPTH];
	logic [1:0] vld_q [DEPTH];

	// queue as seen at the edge, last slot is the incoming compare
	cmp_kind_t kind_v [DEPTH+1];
	data_t [1:0] opd_v [DEPTH+1];
	tag_t [1:0] tag_v [DEPTH+1];
	logic [1:0] vld_v [DEPTH+1];

	data_t imm_ext;
	logic imm_opd;
	data_t [1:0] new_opd;
	tag_t [1:0] new_tag;
	logic [1:0] new_vld;

	assign imm_ext = {{(`DATA_W - `IMM_W){imm[`IMM_W-1]}}, imm};
	assign imm_opd = use_imm && kind != CMP_FZ;

	// a broadcast in the issue cycle is caught as well
	assign new_tag = {opd1_tag, opd0_tag};
	assign new_vld[0] = opd0_valid | (cdb_valid && cdb_tag == opd0_tag);
	assign new_vld[1] = imm_opd | opd1_valid | (cdb_valid && cdb_tag == opd1_tag);
	assign new_opd[0] = opd0_valid ? opd0 : cdb_data;
	assign new_opd[1] = imm_opd ? imm_ext : opd1_valid ? opd1 : cdb_data;

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			if (i < int'(cnt_q)) begin
				kind_v[i] = kind_q[i];
				tag_v[i] = tag_q[i];
				for (int j = 0; j < 2; j++) begin
					vld_v[i][j] = vld_q[i][j] | (cdb_valid && cdb_tag == tag_q[i][j]);
					opd_v[i][j] = vld_q[i][j] ? opd_q[i][j] : cdb_data;
				end
			end else begin
				kind_v[i] = kind;
				tag_v[i] = new_tag;
				vld_v[i] = new_vld;
				opd_v[i] = new_opd;
			end
		end
		kind_v[DEPTH] = kind;
		tag_v[DEPTH] = new_tag;
		vld_v[DEPTH] = new_vld;
		opd_v[DEPTH] = new_opd;
	end

	// only the head may resolve, so results leave in issue order
	assign resolve = cnt_q != 0 && vld_q[0][0] && (kind_q[0] == CMP_FZ || vld_q[0][1]);
	assign resolve_age = done_q[`BR_AGE_W-1:0];

	always_comb begin
		case (kind_q[0])
			CMP_E: outcome = opd_q[0][0] == opd_q[0][1];
			CMP_LE: outcome = $signed(opd_q[0][0]) <= $signed(opd_q[0][1]);
			default: outcome = opd_q[0][0][30:23] == '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			cnt_q <= '0;
			done_q <= '0;
		end else begin
			cnt_q <= cnt_q - resolve + enq;
			done_q <= done_q + resolve - deq_commit;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			kind_q[i] <= kind_v[i + resolve];  // shift by one on resolve
			opd_q[i] <= opd_v[i + resolve];
			tag_q[i] <= tag_v[i + resolve];
			vld_q[i] <= vld_v[i + resolve];
		end
	end

	// the branch queue accept rule keeps a slot free here
	assert property (@(posedge clk) disable iff (reset) enq |-> cnt_q < DEPTH);

endmodule

//--- src/return_stack.sv
`timescale 1ns/1ps
`include "branch_params.svh"

module return_stack (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic push,
	input logic pop,
	input branch_types_pkg::addr_t pc,
	input branch_types_pkg::sp_t restore_ptr,
	output branch_types_pkg::sp_t stack_ptr,
	output branch_types_pkg::addr_t return_addr
);
	import branch_types_pkg::*;

	localparam int ENTRIES = 2 ** `RAS_W;

	addr_t mem [ENTRIES];
	sp_t sp_next;
	logic wr;

	assign wr = push && !flush;

	// stack_ptr points at the current top
	always_comb begin
		if (flush)
			sp_next = restore_ptr;
		else if (push)
			sp_next = stack_ptr + 1'b1;
		else if (pop)
			sp_next = stack_ptr - 1'b1;
		else
			sp_next = stack_ptr;
	end

	always_ff @(posedge clk) begin
		if (wr)
			mem[sp_next] <= pc;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stack_ptr <= '1;
			return_addr <= '0;
		end else begin
			stack_ptr <= sp_next;
			return_addr <= wr ? pc : mem[sp_next];  // new top, bypassing the write
		end
	end

endmodule

//--- src/spec_ctrl.sv
`timescale 1ns/1ps

module spec_ctrl (
	input logic clk,
	input logic reset,
	input logic count_nonzero,
	input logic commit,
	input logic failure,
	output logic flush,
	output logic speculating
);
	import branch_ctrl_pkg::*;

	spec_state_t state;
	spec_state_t state_next;

	always_comb begin
		case (state)
			SPEC_IDLE, SPEC_ACTIVE: begin
				if (commit && failure)
					state_next = SPEC_RECOVER;
				else if (count_nonzero)
					state_next = SPEC_ACTIVE;
				else
					state_next = SPEC_IDLE;
			end
			default: state_next = SPEC_IDLE;  // recovery is a single cycle
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= SPEC_IDLE;
		else
			state <= state_next;
	end

	assign flush = state == SPEC_RECOVER;
	assign speculating = state == SPEC_ACTIVE;

	// a failed commit during recovery would be dropped
	assert property (@(posedge clk) disable iff (reset) flush |-> !commit);

endmodule
